// File: cache_consts.svh
// Geometry is fixed here for exactly two ways and a one-beat 256-bit memory line.
`ifndef CACHE_CONSTS_SVH
`define CACHE_CONSTS_SVH

// Set index width, 8 sets.
`define CACHE_SET_BITS 3

// Byte offset within one line.
`define CACHE_OFFSET_BITS 5

// Address bits above index and offset.
`define CACHE_TAG_BITS 24

// One line is eight 32-bit words.
`define CACHE_LINE_BITS 256

`define CACHE_SETS (1 << `CACHE_SET_BITS)

// Word select inside a line.
`define CACHE_WSEL_BITS (`CACHE_OFFSET_BITS - 2)

// Register block decodes only the low address bits.
`define CACHE_APB_ADDR_BITS 4

// Register byte offsets.
`define CACHE_REG_HITS 4'h0
`define CACHE_REG_MISSES 4'h4
`define CACHE_REG_WBACKS 4'h8
`define CACHE_REG_CTRL 4'hC

`endif

// File: cache_control.sv
// Assumes the CPU holds its request until resp and memory pulses resp once per request.
`timescale 1ns/1ps

module cache_control (
    input  logic                     clk,
    input  logic                     rst,
    input  cache_pkg::cpu_req_t      req,
    input  cache_pkg::cache_status_t status,
    input  logic                     pmem_resp,
    output logic                     resp,
    output logic                     pmem_read,
    output logic                     pmem_write,
    output cache_pkg::cache_ctrl_t   ctrl,
    output cache_pkg::cache_event_t  events
);

    enum logic [1:0] {
        IDLE,
        COMPARE_TAG,
        ALLOCATE,
        WRITE_BACK
    } state, next_state;

    logic retry;   // Second compare after a refill.

    always_comb begin
        next_state = state;
        resp       = 1'b0;
        pmem_read  = 1'b0;
        pmem_write = 1'b0;
        ctrl       = '0;
        events     = '0;
        case (state)
            IDLE: begin
                if (req.read || req.write) begin
                    next_state = COMPARE_TAG;
                end
            end
            COMPARE_TAG: begin
                if (status.hit) begin
                    resp            = 1'b1;
                    ctrl.lru_update = 1'b1;
                    ctrl.cpu_store  = req.write;
                    events.hit      = !retry;   // Refill hit is not a hit.
                    next_state      = IDLE;
                end else begin
                    events.miss = 1'b1;
                    if (status.victim_dirty) begin
                        next_state = WRITE_BACK;
                    end else begin
                        next_state = ALLOCATE;
                    end
                end
            end
            ALLOCATE: begin
                pmem_read = 1'b1;
                if (pmem_resp) begin
                    ctrl.refill_load = 1'b1;   // Line lands with the pulse.
                    next_state       = COMPARE_TAG;
                end
            end
            WRITE_BACK: begin
                pmem_write     = 1'b1;
                ctrl.wb_select = 1'b1;
                if (pmem_resp) begin
                    events.wback = 1'b1;
                    next_state   = ALLOCATE;
                end
            end
            default: begin
                next_state = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
        end else begin
            state <= next_state;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            retry <= 1'b0;
        end else if (ctrl.refill_load) begin
            retry <= 1'b1;
        end else if (resp) begin
            retry <= 1'b0;   // Request finished.
        end
    end

    // Memory sees one command at a time.
    a_pmem_exclusive: assert property (
        @(posedge clk) disable iff (rst)
        !(pmem_read && pmem_write)
    ) else $error("pmem read and write both high");

    // CPU response only comes out of a tag compare.
    a_resp_in_compare: assert property (
        @(posedge clk) disable iff (rst)
        resp |-> (state == COMPARE_TAG)
    ) else $error("resp outside compare tag");

endmodule

// File: cache_datapath.sv
// Two ways only, victim is the way the per-set PLRU bit did not mark most recent.
`timescale 1ns/1ps
`include "cache_consts.svh"

module cache_datapath (
    input  logic                        clk,
    input  logic                        rst,
    input  cache_pkg::cpu_req_t         req,
    input  cache_pkg::cache_ctrl_t      ctrl,
    input  logic [`CACHE_LINE_BITS-1:0] pmem_rdata,
    output cache_pkg::cache_status_t    status,
    output logic [31:0]                 rdata,
    output logic [31:0]                 pmem_addr,
    output logic [`CACHE_LINE_BITS-1:0] pmem_wdata
);

    logic [`CACHE_TAG_BITS-1:0]  tag_arr   [2][`CACHE_SETS];
    logic [`CACHE_LINE_BITS-1:0] data_arr  [2][`CACHE_SETS];
    logic                        valid_arr [2][`CACHE_SETS];
    logic                        dirty_arr [2][`CACHE_SETS];
    logic [`CACHE_SETS-1:0]      plru;   // Most recently used way.

    logic [`CACHE_SET_BITS-1:0]  index;
    logic [`CACHE_TAG_BITS-1:0]  tag;
    logic [`CACHE_WSEL_BITS-1:0] wsel;
    logic [1:0]                  way_hit;
    logic                        hit_way;
    logic                        victim;
    logic [`CACHE_LINE_BITS-1:0] hit_line;
    logic [`CACHE_LINE_BITS-1:0] merged_line;

    assign index = req.addr.f.index;
    assign tag   = req.addr.f.tag;
    assign wsel  = req.addr.f.wsel;

    assign way_hit[0] = valid_arr[0][index] && (tag_arr[0][index] == tag);
    assign way_hit[1] = valid_arr[1][index] && (tag_arr[1][index] == tag);
    assign hit_way    = way_hit[1];
    assign victim     = ~plru[index];

    assign hit_line = data_arr[hit_way][index];
    assign rdata    = hit_line[wsel*32 +: 32];

    always_comb begin
        merged_line = hit_line;
        for (int b = 0; b < 4; b++) begin
            if (req.byte_en[b]) begin
                merged_line[wsel*32 + b*8 +: 8] = req.wdata[b*8 +: 8];
            end
        end
    end

    always_comb begin
        status.hit          = |way_hit;
        status.way_hit      = way_hit;
        status.victim       = victim;
        status.victim_dirty = valid_arr[victim][index] && dirty_arr[victim][index];
    end

    // Write back goes to the victim's own address.
    assign pmem_addr = {ctrl.wb_select ? tag_arr[victim][index] : tag, index,
                        {`CACHE_OFFSET_BITS{1'b0}}};
    assign pmem_wdata = data_arr[victim][index];

    always_ff @(posedge clk) begin
        if (ctrl.refill_load) begin
            tag_arr[victim][index]  <= tag;
            data_arr[victim][index] <= pmem_rdata;
        end else if (ctrl.cpu_store) begin
            data_arr[hit_way][index] <= merged_line;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            plru <= '0;
            for (int w = 0; w < 2; w++) begin
                for (int s = 0; s < `CACHE_SETS; s++) begin
                    valid_arr[w][s] <= 1'b0;
                    dirty_arr[w][s] <= 1'b0;
                end
            end
        end else begin
            if (ctrl.refill_load) begin
                valid_arr[victim][index] <= 1'b1;
                dirty_arr[victim][index] <= 1'b0;   // Fresh from memory.
            end
            if (ctrl.cpu_store) begin
                dirty_arr[hit_way][index] <= 1'b1;
            end
            if (ctrl.lru_update) begin
                plru[index] <= hit_way;
            end
        end
    end

    // Same tag never sits in both ways of a set.
    a_way_hit_onehot: assert property (
        @(posedge clk) disable iff (rst)
        $onehot0(way_hit)
    ) else $error("tag hit in both ways");

endmodule

// File: cache_pkg.sv
// Types assume a 32-bit CPU address and the fixed geometry of the constants header.
`include "cache_consts.svh"

package cache_pkg;

    // Same word, read raw or split into its fields.
    typedef union packed {
        logic [31:0] raw;
        struct packed {
            logic [`CACHE_TAG_BITS-1:0]  tag;
            logic [`CACHE_SET_BITS-1:0]  index;
            logic [`CACHE_WSEL_BITS-1:0] wsel;
            logic [1:0]                  boff;
        } f;
    } cache_addr_u;

    typedef struct packed {
        logic        read;
        logic        write;
        cache_addr_u addr;
        logic [31:0] wdata;
        logic [3:0]  byte_en;
    } cpu_req_t;

    typedef struct packed {
        logic        resp;
        logic [31:0] rdata;
    } cpu_rsp_t;

    typedef struct packed {
        logic                        read;
        logic                        write;
        logic [31:0]                 addr;   // Line aligned.
        logic [`CACHE_LINE_BITS-1:0] wdata;
    } pmem_req_t;

    typedef struct packed {
        logic                        resp;
        logic [`CACHE_LINE_BITS-1:0] rdata;
    } pmem_rsp_t;

    typedef struct packed {
        logic refill_load;
        logic cpu_store;
        logic lru_update;
        logic wb_select;
    } cache_ctrl_t;

    typedef struct packed {
        logic       hit;
        logic [1:0] way_hit;
        logic       victim;
        logic       victim_dirty;
    } cache_status_t;

    typedef struct packed {
        logic hit;
        logic miss;
        logic wback;
    } cache_event_t;

    typedef struct packed {
        logic                            psel;
        logic                            penable;
        logic                            pwrite;
        logic [`CACHE_APB_ADDR_BITS-1:0] paddr;
        logic [31:0]                     pwdata;
    } apb_req_t;

    typedef struct packed {
        logic [31:0] prdata;
        logic        pready;
        logic        pslverr;
    } apb_rsp_t;

endpackage

// File: cache_regs.sv
// APB slave with zero wait states; counters saturate and clear when CTRL bit 0 is written.
`timescale 1ns/1ps
`include "cache_consts.svh"

module cache_regs (
    input  logic                    clk,
    input  logic                    rst,
    input  cache_pkg::apb_req_t     apb_req,
    input  cache_pkg::cache_event_t events,
    output cache_pkg::apb_rsp_t     apb_rsp
);

    logic [31:0] hits;
    logic [31:0] misses;
    logic [31:0] wbacks;
    logic        access;
    logic        reg_ok;
    logic        clear;
    logic [31:0] rd_mux;

    function automatic logic [31:0] sat_inc(input logic [31:0] v, input logic en);
        if (en && (v != '1)) begin
            return v + 32'd1;
        end
        return v;
    endfunction

    assign access = apb_req.psel && apb_req.penable;
    assign clear  = access && apb_req.pwrite && (apb_req.paddr == `CACHE_REG_CTRL) &&
                    apb_req.pwdata[0];

    always_comb begin
        reg_ok = 1'b1;
        rd_mux = '0;
        case (apb_req.paddr)
            `CACHE_REG_HITS:   rd_mux = hits;
            `CACHE_REG_MISSES: rd_mux = misses;
            `CACHE_REG_WBACKS: rd_mux = wbacks;
            `CACHE_REG_CTRL:   rd_mux = '0;   // Write only.
            default:           reg_ok = 1'b0;
        endcase
    end

    always_comb begin
        apb_rsp.prdata  = rd_mux;
        apb_rsp.pready  = 1'b1;
        apb_rsp.pslverr = access && !reg_ok;
    end

    always_ff @(posedge clk) begin
        if (rst || clear) begin
            hits   <= '0;
            misses <= '0;
            wbacks <= '0;
        end else begin
            hits   <= sat_inc(hits, events.hit);
            misses <= sat_inc(misses, events.miss);
            wbacks <= sat_inc(wbacks, events.wback);
        end
    end

    // Controller states are exclusive, so at most one event per cycle.
    a_single_event: assert property (
        @(posedge clk) disable iff (rst)
        $onehot0({events.hit, events.miss, events.wback})
    ) else $error("more than one cache event in a cycle");

endmodule

// File: cache_top.sv
// Cache between a 32-bit CPU port and a one-beat line memory, with APB counters beside it.
`timescale 1ns/1ps
`include "cache_consts.svh"

module cache_top (
    input  logic                 clk,
    input  logic                 rst,
    input  cache_pkg::cpu_req_t  cpu_req,
    output cache_pkg::cpu_rsp_t  cpu_rsp,
    output cache_pkg::pmem_req_t pmem_req,
    input  cache_pkg::pmem_rsp_t pmem_rsp,
    input  cache_pkg::apb_req_t  apb_req,
    output cache_pkg::apb_rsp_t  apb_rsp
);

    cache_pkg::cache_ctrl_t      ctrl;
    cache_pkg::cache_status_t    status;
    cache_pkg::cache_event_t     events;
    logic                        resp;
    logic                        pmem_read;
    logic                        pmem_write;
    logic [31:0]                 rdata;
    logic [31:0]                 pmem_addr;
    logic [`CACHE_LINE_BITS-1:0] pmem_wdata;

    always_comb begin
        cpu_rsp.resp   = resp;
        cpu_rsp.rdata  = rdata;
        pmem_req.read  = pmem_read;
        pmem_req.write = pmem_write;
        pmem_req.addr  = pmem_addr;
        pmem_req.wdata = pmem_wdata;
    end

    cache_control u_control (
        .clk        (clk),
        .rst        (rst),
        .req        (cpu_req),
        .status     (status),
        .pmem_resp  (pmem_rsp.resp),
        .resp       (resp),
        .pmem_read  (pmem_read),
        .pmem_write (pmem_write),
        .ctrl       (ctrl),
        .events     (events)
    );

    cache_datapath u_datapath (
        .clk        (clk),
        .rst        (rst),
        .req        (cpu_req),
        .ctrl       (ctrl),
        .pmem_rdata (pmem_rsp.rdata),
        .status     (status),
        .rdata      (rdata),
        .pmem_addr  (pmem_addr),
        .pmem_wdata (pmem_wdata)
    );

    cache_regs u_regs (
        .clk     (clk),
        .rst     (rst),
        .apb_req (apb_req),
        .events  (events),
        .apb_rsp (apb_rsp)
    );

endmodule

// File: run.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
log=sim.log

if ! verilator --binary --timing --assert --top-module tb_top -f vlog.f -Mdir obj_dir -o tb_sim; then
    echo "Verilator build failed"
    exit 1
fi

if ! ./obj_dir/tb_sim > "$log" 2>&1; then
    cat "$log"
    echo "Simulation exited with an error"
    exit 1
fi

cat "$log"
if grep -qx "STATUS: PASS" "$log"; then
    exit 0
fi
echo "Pass message not found in $log"
exit 1

// File: tb_checker.sv
// Reference model assumes the CPU holds each request until resp and APB runs only while idle.
`timescale 1ns/1ps
`include "cache_consts.svh"

module tb_checker (
    input logic                 clk,
    input logic                 rst,
    input cache_pkg::cpu_req_t  cpu_req,
    input cache_pkg::cpu_rsp_t  cpu_rsp,
    input cache_pkg::pmem_req_t pmem_req,
    input cache_pkg::pmem_rsp_t pmem_rsp,
    input cache_pkg::apb_req_t  apb_req,
    input cache_pkg::apb_rsp_t  apb_rsp
);

    int errors = 0;
    int checks = 0;
    int completed = 0;
    int cyc = 0;
    int start_cyc = 0;
    logic after_rst = 1'b0;
    logic busy = 1'b0;
    logic pred_hit;
    logic pred_wb;
    logic wb_seen;
    logic [31:0] wb_addr;
    logic [31:0] exp_hits;
    logic [31:0] exp_misses;
    logic [31:0] exp_wbacks;
    logic [`CACHE_TAG_BITS-1:0] m_tag [`CACHE_SETS][2];
    logic m_valid [`CACHE_SETS][2];
    logic m_dirty [`CACHE_SETS][2];
    logic m_mru [`CACHE_SETS];            // Way used last.
    logic [7:0] ref_mem [logic [31:0]];   // Bytes written by the CPU.

    function automatic logic [7:0] ref_byte(input logic [31:0] a);
        logic [31:0] w;
        if (ref_mem.exists(a)) begin
            return ref_mem[a];
        end
        w = {a[31:2], 2'b00} ^ 32'h5A5A_C3C3;   // Untouched memory fill.
        return w[a[1:0]*8 +: 8];
    endfunction

    function automatic logic [31:0] ref_word(input logic [31:0] a);
        return {ref_byte(a + 3), ref_byte(a + 2), ref_byte(a + 1), ref_byte(a)};
    endfunction

    function automatic logic [`CACHE_LINE_BITS-1:0] ref_line(input logic [31:0] a);
        logic [`CACHE_LINE_BITS-1:0] line;
        for (int k = 0; k < 8; k++) begin
            line[k*32 +: 32] = ref_word(a + k * 4);
        end
        return line;
    endfunction

    task automatic check_word(input string name, input logic [31:0] exp,
                              input logic [31:0] act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("FAIL %s: expected %h, actual %h at %0t", name, exp, act, $time);
        end
    endtask

    task automatic check_line(input string name, input logic [`CACHE_LINE_BITS-1:0] exp,
                              input logic [`CACHE_LINE_BITS-1:0] act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("FAIL %s: expected %h, actual %h at %0t", name, exp, act, $time);
        end
    endtask

    task automatic flag_error(input string msg);
        errors++;
        $display("ERROR: %s at %0t", msg, $time);
    endtask

    task automatic reset_model();
        busy       = 1'b0;
        exp_hits   = '0;
        exp_misses = '0;
        exp_wbacks = '0;
        for (int s = 0; s < `CACHE_SETS; s++) begin
            m_valid[s][0] = 1'b0;
            m_valid[s][1] = 1'b0;
            m_dirty[s][0] = 1'b0;
            m_dirty[s][1] = 1'b0;
            m_mru[s]      = 1'b0;
        end
    endtask

    // Predicts the outcome of a new request and moves the LRU model on.
    task automatic start_request();
        logic [`CACHE_SET_BITS-1:0] s;
        logic [`CACHE_TAG_BITS-1:0] t;
        logic way;
        s        = cpu_req.addr.f.index;
        t        = cpu_req.addr.f.tag;
        pred_hit = 1'b1;
        pred_wb  = 1'b0;
        wb_seen  = 1'b0;
        way      = 1'b0;
        if (m_valid[s][0] && m_tag[s][0] == t) begin
            way = 1'b0;
        end else if (m_valid[s][1] && m_tag[s][1] == t) begin
            way = 1'b1;
        end else begin
            pred_hit = 1'b0;
            way      = !m_mru[s];   // Least recently used.
            exp_misses++;
            if (m_valid[s][way] && m_dirty[s][way]) begin
                pred_wb = 1'b1;
                exp_wbacks++;
                wb_addr = {m_tag[s][way], s, {`CACHE_OFFSET_BITS{1'b0}}};
            end
            m_tag[s][way]   = t;
            m_valid[s][way] = 1'b1;
            m_dirty[s][way] = 1'b0;
        end
        if (pred_hit) begin
            exp_hits++;
        end
        if (cpu_req.write) begin
            m_dirty[s][way] = 1'b1;
        end
        m_mru[s]  = way;
        busy      = 1'b1;
        start_cyc = cyc;
    endtask

    task automatic finish_request();
        logic [31:0] a;
        a = {cpu_req.addr.raw[31:2], 2'b00};
        if (pred_hit) begin
            check_word("hit_latency", 32'd2, cyc - start_cyc + 1);
        end
        if (pred_wb && !wb_seen) begin
            flag_error("predicted write-back never reached memory");
        end
        if (cpu_req.read) begin
            check_word("read_data", ref_word(a), cpu_rsp.rdata);
        end else begin
            for (int b = 0; b < 4; b++) begin
                if (cpu_req.byte_en[b]) begin
                    ref_mem[a + b] = cpu_req.wdata[b*8 +: 8];
                end
            end
        end
        busy = 1'b0;
        completed++;
    endtask

    task automatic watch_cpu();
        if (!busy && (cpu_req.read || cpu_req.write)) begin
            start_request();
        end else if (busy && cpu_rsp.resp) begin
            finish_request();
        end else if (!busy && cpu_rsp.resp) begin
            flag_error("CPU resp without a pending request");
        end
    endtask

    task automatic watch_memory();
        if (pmem_rsp.resp && pmem_req.write) begin
            if (!busy || !pred_wb || wb_seen) begin
                flag_error("write-back that the LRU model did not predict");
            end else begin
                check_word("wb_addr", wb_addr, pmem_req.addr);
                check_line("wb_data", ref_line(wb_addr), pmem_req.wdata);
                wb_seen = 1'b1;
            end
        end else if (pmem_rsp.resp && pmem_req.read) begin
            if (!busy || pred_hit) begin
                flag_error("refill read that the LRU model did not predict");
            end else begin
                check_word("refill_addr", {cpu_req.addr.raw[31:`CACHE_OFFSET_BITS],
                           {`CACHE_OFFSET_BITS{1'b0}}}, pmem_req.addr);
            end
        end
    endtask

    task automatic check_apb(input string name, input logic [31:0] exp);
        check_word("apb_pslverr", 32'd0, {31'd0, apb_rsp.pslverr});
        if (!apb_req.pwrite) begin
            check_word(name, exp, apb_rsp.prdata);
        end
    endtask

    task automatic watch_apb();
        if (apb_req.psel && apb_req.penable) begin
            check_word("apb_pready", 32'd1, {31'd0, apb_rsp.pready});
            case (apb_req.paddr)
                `CACHE_REG_HITS:   check_apb("apb_hits", exp_hits);
                `CACHE_REG_MISSES: check_apb("apb_misses", exp_misses);
                `CACHE_REG_WBACKS: check_apb("apb_wbacks", exp_wbacks);
                `CACHE_REG_CTRL:   check_apb("apb_ctrl", 32'd0);
                default:           check_word("apb_pslverr", 32'd1, {31'd0, apb_rsp.pslverr});
            endcase
            if (apb_req.pwrite && apb_req.paddr == `CACHE_REG_CTRL && apb_req.pwdata[0]) begin
                exp_hits   = '0;   // Counters clear on this edge.
                exp_misses = '0;
                exp_wbacks = '0;
            end
        end
    endtask

    always @(posedge clk) begin
        cyc++;
        if (rst) begin
            reset_model();
            after_rst = 1'b1;
        end else begin
            if (after_rst) begin
                check_word("reset_outputs", 32'd0, {28'd0, cpu_rsp.resp, pmem_req.read,
                                                    pmem_req.write, apb_rsp.pslverr});
                after_rst = 1'b0;
            end
            watch_memory();
            watch_cpu();
            watch_apb();
        end
    end

endmodule

// File: tb_top.sv
// Memory model answers in 1 to 4 cycles; APB accesses are issued only while the cache is idle.
`timescale 1ns/1ps
`include "cache_consts.svh"

module tb_top;

    localparam int REQUESTS       = 400;
    localparam int TIMEOUT_CYCLES = REQUESTS * 20 + 200;

    logic                 clk;
    logic                 rst;
    cache_pkg::cpu_req_t  cpu_req;
    cache_pkg::cpu_rsp_t  cpu_rsp;
    cache_pkg::pmem_req_t pmem_req;
    cache_pkg::pmem_rsp_t pmem_rsp;
    cache_pkg::apb_req_t  apb_req;
    cache_pkg::apb_rsp_t  apb_rsp;

    int seed = 26927;
    int cycles = 0;
    int stim_errors = 0;
    logic [`CACHE_LINE_BITS-1:0] mem_lines [logic [31:0]];   // Lines written back.

    cache_top uut (
        .clk      (clk),
        .rst      (rst),
        .cpu_req  (cpu_req),
        .cpu_rsp  (cpu_rsp),
        .pmem_req (pmem_req),
        .pmem_rsp (pmem_rsp),
        .apb_req  (apb_req),
        .apb_rsp  (apb_rsp)
    );

    tb_checker chk (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic logic [`CACHE_LINE_BITS-1:0] read_line(input logic [31:0] a);
        logic [`CACHE_LINE_BITS-1:0] line;
        logic [31:0] w;
        if (mem_lines.exists(a)) begin
            return mem_lines[a];
        end
        for (int k = 0; k < 8; k++) begin
            w = a + k * 4;
            line[k*32 +: 32] = w ^ 32'h5A5A_C3C3;   // Word address sets the fill.
        end
        return line;
    endfunction

    // Three tags per set force conflicts in a two-way cache.
    function automatic logic [`CACHE_TAG_BITS-1:0] tag_for(input int pick);
        logic [`CACHE_TAG_BITS-1:0] t;
        case (pick)
            0:       t = 24'h00_0101;
            1:       t = 24'h00_A0A0;
            default: t = 24'h3C_0F00;
        endcase
        return t;
    endfunction

    task automatic wait_cpu_resp();
        do begin
            @(posedge clk);
        end while (!cpu_rsp.resp);
        #1;
        cpu_req.read  = 1'b0;
        cpu_req.write = 1'b0;
    endtask

    task automatic apb_access(input logic wr, input logic [3:0] addr, input logic [31:0] data);
        apb_req.psel    = 1'b1;
        apb_req.penable = 1'b0;
        apb_req.pwrite  = wr;
        apb_req.paddr   = addr;
        apb_req.pwdata  = data;
        @(posedge clk);
        #1;
        apb_req.penable = 1'b1;
        @(posedge clk);
        #1;
        apb_req = '0;
    endtask

    task automatic read_counters();
        apb_access(1'b0, `CACHE_REG_HITS, 32'd0);
        apb_access(1'b0, `CACHE_REG_MISSES, 32'd0);
        apb_access(1'b0, `CACHE_REG_WBACKS, 32'd0);
        apb_access(1'b0, `CACHE_REG_CTRL, 32'd0);
    endtask

    initial begin : memory_model
        int lat;
        pmem_rsp = '0;
        forever begin
            @(posedge clk);
            if (!rst && (pmem_req.read || pmem_req.write)) begin
                lat = $unsigned($random(seed)) % 4;
                repeat (lat) @(posedge clk);
                #1;
                if (pmem_req.write) begin
                    mem_lines[pmem_req.addr] = pmem_req.wdata;
                end else begin
                    pmem_rsp.rdata = read_line(pmem_req.addr);
                end
                pmem_rsp.resp = 1'b1;
                @(posedge clk);
                #1;
                pmem_rsp.resp = 1'b0;
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("Timeout after %0d cycles, %0d requests done", cycles, chk.completed);
            $display("STATUS: FAIL");
            $finish;
        end
    end

    initial begin : stimulus
        logic [31:0] rnd;
        int pick;
        int total;
        cpu_req = '0;
        apb_req = '0;
        rst     = 1'b1;
        repeat (2) @(posedge clk);
        #1;
        rst = 1'b0;
        @(posedge clk);
        #1;
        read_counters();
        apb_access(1'b0, 4'h2, 32'd0);   // Unmapped offset.
        for (int i = 0; i < REQUESTS; i++) begin
            pick = $unsigned($random(seed)) % 3;
            rnd  = $random(seed);
            cpu_req.addr.f.tag   = tag_for(pick);
            cpu_req.addr.f.index = rnd[2:0];
            cpu_req.addr.f.wsel  = rnd[5:3];
            cpu_req.addr.f.boff  = 2'b00;
            cpu_req.byte_en      = rnd[9:6];
            cpu_req.wdata        = $random(seed);
            cpu_req.write        = rnd[10];
            cpu_req.read         = !rnd[10];
            wait_cpu_resp();
        end
        read_counters();
        apb_access(1'b1, `CACHE_REG_CTRL, 32'd1);
        read_counters();
        apb_access(1'b0, 4'h6, 32'd0);
        repeat (2) @(posedge clk);
        if (chk.completed != REQUESTS) begin
            $display("ERROR: only %0d of %0d requests completed", chk.completed, REQUESTS);
            stim_errors++;
        end
        total = chk.errors + stim_errors;
        $display("Errors: %0d, checks: %0d, requests: %0d", total, chk.checks, chk.completed);
        if (total == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

// File: vlog.f
+incdir+.
cache_pkg.sv
cache_control.sv
cache_datapath.sv
cache_regs.sv
cache_top.sv
tb_checker.sv
tb_top.sv
